// ==== verilog/l1_store_pkg.sv ====
// Shared widths, L2 opcodes and request/response structs for the L1 store path and its testbench
`default_nettype none

package l1_store_pkg;

	// Strand and address geometry is fixed by the 26-bit L2 address
	localparam int NUM_STRANDS = 4;
	localparam int STRAND_W = 2;
	localparam int TAG_W = 20;
	localparam int SET_W = 6;
	localparam int LINE_BITS = 512;
	localparam int MASK_BITS = 64;

	typedef enum logic [2:0]
	{
		L2_STORE      = 3'd1,
		L2_STORE_SYNC = 3'd5
	} l2_op_e;

	typedef logic [NUM_STRANDS-1:0] strand_mask_t;

	// One request per cycle from the L1 pipeline; write clear means a load probe
	typedef struct packed
	{
		logic                  write;
		logic                  synchronized;
		logic [STRAND_W-1:0]   strand;
		logic [TAG_W-1:0]      tag;
		logic [SET_W-1:0]      set;
		logic [MASK_BITS-1:0]  mask;
		logic [LINE_BITS-1:0]  data;
	} store_req_t;

	// The address is the tag above the set index
	typedef struct packed
	{
		l2_op_e                   op;
		logic [STRAND_W-1:0]      strand;
		logic [TAG_W+SET_W-1:0]   address;
		logic [MASK_BITS-1:0]     mask;
		logic [LINE_BITS-1:0]     data;
	} l2_req_t;

	// from_stbuf marks responses that belong to the store buffer
	typedef struct packed
	{
		logic                  valid;
		logic                  status;
		logic                  from_stbuf;
		logic [STRAND_W-1:0]   strand;
		logic                  update;
	} l2_resp_t;

endpackage

`default_nettype wire

// ==== verilog/rr_arbiter4.sv ====
// Four-way round-robin arbiter for store issue; priority rotates only while rotate_i is high
`default_nettype none
`timescale 1ns/100ps

module rr_arbiter4
(
	input  wire                        clk,
	input  wire                        rst_n_i,
	input  wire l1_store_pkg::strand_mask_t request_i,
	input  wire                        rotate_i,
	output l1_store_pkg::strand_mask_t grant_o
);

	logic [l1_store_pkg::STRAND_W-1:0] last_q;
	logic [l1_store_pkg::STRAND_W-1:0] grant_idx;
	logic [l1_store_pkg::STRAND_W-1:0] idx;
	logic                              found;

	// Search starts one past the last granted strand and wraps around
	always_comb
	begin
		grant_o = '0;
		grant_idx = last_q;
		idx = last_q;
		found = 1'b0;
		for (int k = 1; k <= l1_store_pkg::NUM_STRANDS; k++)
		begin
			idx = last_q + k[l1_store_pkg::STRAND_W-1:0];
			if (!found && request_i[idx])
			begin
				found = 1'b1;
				grant_idx = idx;
				grant_o[idx] = 1'b1;
			end
		end
	end

	// Strand 0 gets first priority out of reset
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			last_q <= '1;
		else if (rotate_i && found)
			last_q <= grant_idx;
	end

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(grant_o));

endmodule

`default_nettype wire

// ==== verilog/sync_store_tracker.sv ====
// Tracks synchronized stores per strand and produces their rollback, resume and result bits
`default_nettype none
`timescale 1ns/100ps

module sync_store_tracker
(
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire l1_store_pkg::store_req_t req_i,
	input  wire l1_store_pkg::strand_mask_t entry_busy_i,
	input  wire l1_store_pkg::l2_resp_t   resp_i,
	output logic                         need_sync_rollback_o,
	output logic                         sync_rollback_o,
	output l1_store_pkg::strand_mask_t   sync_resume_o,
	output l1_store_pkg::strand_mask_t   sync_result_o
);

	l1_store_pkg::strand_mask_t waiting_q;
	l1_store_pkg::strand_mask_t complete_q;
	l1_store_pkg::strand_mask_t result_q;
	l1_store_pkg::strand_mask_t sync_req_mask;
	l1_store_pkg::strand_mask_t resp_mask;

	// A sync store only counts when its entry is free; otherwise the full rollback handles it
	assign sync_req_mask = (req_i.write && req_i.synchronized && !entry_busy_i[req_i.strand])
		? l1_store_pkg::strand_mask_t'(1) << req_i.strand : '0;
	assign resp_mask = (resp_i.valid && resp_i.from_stbuf)
		? l1_store_pkg::strand_mask_t'(1) << resp_i.strand : '0;

	// A strand that already has its L2 answer replays without a second rollback
	assign need_sync_rollback_o = |(sync_req_mask & ~complete_q);
	assign sync_resume_o = waiting_q & resp_mask;
	assign sync_result_o = result_q;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			waiting_q <= '0;
			complete_q <= '0;
			result_q <= '0;
			sync_rollback_o <= 1'b0;
		end
		else
		begin
			waiting_q <= (waiting_q | (sync_req_mask & ~complete_q)) & ~resp_mask;
			complete_q <= (complete_q | (waiting_q & resp_mask)) & ~sync_req_mask;
			if (|(waiting_q & resp_mask))
				result_q[resp_i.strand] <= resp_i.status;
			sync_rollback_o <= need_sync_rollback_o;
		end
	end

	wait_xor_complete: assert property (@(posedge clk) disable iff (!rst_n_i)
		(waiting_q & complete_q) == '0);

	// The strand is stalled by the rollback until the response resumes it
	no_sync_while_waiting: assert property (@(posedge clk) disable iff (!rst_n_i)
		(waiting_q & sync_req_mask) == '0);

endmodule

`default_nettype wire

// ==== verilog/store_buffer.sv ====
// Per-strand store entries with L2 issue, same-strand load bypass, rollback and resume
`default_nettype none
`timescale 1ns/100ps

module store_buffer
(
	input  wire                                     clk,
	input  wire                                     rst_n_i,
	input  wire l1_store_pkg::store_req_t           req_i,
	input  wire                                     need_sync_rollback_i,
	input  wire l1_store_pkg::strand_mask_t         sync_result_i,
	input  wire l1_store_pkg::strand_mask_t         sync_resume_i,
	input  wire                                     sync_rollback_i,
	input  wire l1_store_pkg::strand_mask_t         grant_i,
	input  wire l1_store_pkg::l2_resp_t             resp_i,
	input  wire                                     l2_ack_i,
	output l1_store_pkg::strand_mask_t              pending_o,
	output logic                                    rotate_o,
	output l1_store_pkg::strand_mask_t              entry_busy_o,
	output logic                                    l2_req_valid_o,
	output l1_store_pkg::l2_req_t                   l2_req_o,
	output logic [l1_store_pkg::LINE_BITS-1:0]      bypass_data_o,
	output logic [l1_store_pkg::MASK_BITS-1:0]      bypass_mask_o,
	output logic                                    rollback_o,
	output l1_store_pkg::strand_mask_t              resume_strands_o,
	output logic                                    store_update_o,
	output logic [l1_store_pkg::SET_W-1:0]          store_update_set_o
);

	typedef struct packed
	{
		logic                                  sync;
		logic [l1_store_pkg::TAG_W-1:0]        tag;
		logic [l1_store_pkg::SET_W-1:0]        set;
		logic [l1_store_pkg::MASK_BITS-1:0]    mask;
		logic [l1_store_pkg::LINE_BITS-1:0]    data;
	} entry_t;

	entry_t                             entries_q [l1_store_pkg::NUM_STRANDS];
	entry_t                             issue_entry;
	entry_t                             req_entry;
	l1_store_pkg::strand_mask_t         enqueued_q;
	l1_store_pkg::strand_mask_t         acked_q;
	l1_store_pkg::strand_mask_t         full_wait_q;
	l1_store_pkg::strand_mask_t         finish_mask;
	l1_store_pkg::strand_mask_t         req_mask;
	logic [l1_store_pkg::STRAND_W-1:0]  issue_idx_q;
	logic [l1_store_pkg::STRAND_W-1:0]  grant_idx;
	logic                               wait_ack_q;
	logic                               stbuf_full_q;
	logic                               resp_hit;
	logic                               store_complete;
	logic                               collision;
	logic                               enqueue;
	logic [l1_store_pkg::MASK_BITS-1:0] raw_mask;
	logic [l1_store_pkg::LINE_BITS-1:0] raw_data;

	assign resp_hit = resp_i.valid && resp_i.from_stbuf;
	assign store_complete = resp_hit && enqueued_q[resp_i.strand];
	// A response in the same cycle frees the entry for the new store of that strand
	assign collision = store_complete && req_i.write && req_i.strand == resp_i.strand;
	assign enqueue = req_i.write && (!enqueued_q[req_i.strand] || collision)
		&& (!req_i.synchronized || need_sync_rollback_i);

	assign finish_mask = resp_hit ? l1_store_pkg::strand_mask_t'(1) << resp_i.strand : '0;
	assign req_mask = l1_store_pkg::strand_mask_t'(1) << req_i.strand;

	assign pending_o = enqueued_q & ~acked_q;
	assign rotate_o = !wait_ack_q;
	assign entry_busy_o = enqueued_q;

	always_comb
	begin
		grant_idx = '0;
		for (int k = 0; k < l1_store_pkg::NUM_STRANDS; k++)
		begin
			if (grant_i[k])
				grant_idx = k[l1_store_pkg::STRAND_W-1:0];
		end
	end

	// The issued entry cannot change until its response, so the request is stable
	assign issue_entry = entries_q[issue_idx_q];
	assign l2_req_valid_o = wait_ack_q;
	assign l2_req_o.op = issue_entry.sync ? l1_store_pkg::L2_STORE_SYNC : l1_store_pkg::L2_STORE;
	assign l2_req_o.strand = issue_idx_q;
	assign l2_req_o.address = {issue_entry.tag, issue_entry.set};
	assign l2_req_o.mask = issue_entry.mask;
	assign l2_req_o.data = issue_entry.data;

	assign store_update_o = resp_hit && resp_i.update;
	assign store_update_set_o = resp_hit ? entries_q[resp_i.strand].set : '0;

	assign rollback_o = stbuf_full_q || sync_rollback_i;

	// Only the same strand's entry may forward data to a load
	assign req_entry = entries_q[req_i.strand];
	always_comb
	begin
		raw_mask = '0;
		raw_data = '0;
		if (enqueued_q[req_i.strand] && req_entry.tag == req_i.tag
			&& req_entry.set == req_i.set)
		begin
			raw_mask = req_entry.mask;
			raw_data = req_entry.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue)
			entries_q[req_i.strand] <= {req_i.synchronized, req_i.tag, req_i.set,
				req_i.mask, req_i.data};
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			enqueued_q <= '0;
			acked_q <= '0;
			issue_idx_q <= '0;
			wait_ack_q <= 1'b0;
			full_wait_q <= '0;
			stbuf_full_q <= 1'b0;
			resume_strands_o <= '0;
			bypass_mask_o <= '0;
			bypass_data_o <= '0;
		end
		else
		begin
			if (store_complete)
			begin
				acked_q[resp_i.strand] <= 1'b0;
				if (!collision)
					enqueued_q[resp_i.strand] <= 1'b0;
			end
			if (enqueue)
				enqueued_q[req_i.strand] <= 1'b1;

			// One request in flight; the next grant is taken the cycle after the ack
			if (wait_ack_q)
			begin
				if (l2_ack_i)
				begin
					acked_q[issue_idx_q] <= 1'b1;
					wait_ack_q <= 1'b0;
				end
			end
			else if (|grant_i)
			begin
				issue_idx_q <= grant_idx;
				wait_ack_q <= 1'b1;
			end

			// Strands stalled on a full entry wait for that entry's response
			if (req_i.write && enqueued_q[req_i.strand] && !collision)
			begin
				full_wait_q <= (full_wait_q & ~finish_mask) | req_mask;
				stbuf_full_q <= 1'b1;
			end
			else
			begin
				full_wait_q <= full_wait_q & ~finish_mask;
				stbuf_full_q <= 1'b0;
			end
			resume_strands_o <= (finish_mask & full_wait_q) | sync_resume_i;

			// A synchronized store returns its L2 status in bit 0 of each word
			if (req_i.write && req_i.synchronized)
			begin
				bypass_mask_o <= '1;
				bypass_data_o <= {(l1_store_pkg::LINE_BITS/32){{31'b0,
					sync_result_i[req_i.strand]}}};
			end
			else
			begin
				bypass_mask_o <= raw_mask;
				bypass_data_o <= raw_data;
			end
		end
	end

	resp_matches_entry: assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_hit |-> (enqueued_q[resp_i.strand] && acked_q[resp_i.strand]));

endmodule

`default_nettype wire

// ==== verilog/store_subsystem.sv ====
// Top of the L1 store path; connects the store buffer, the issue arbiter and the sync tracker
`default_nettype none
`timescale 1ns/100ps

module store_subsystem
(
	input  wire                                 clk,
	input  wire                                 rst_n_i,
	input  wire l1_store_pkg::store_req_t       req_i,
	input  wire                                 l2_ack_i,
	input  wire l1_store_pkg::l2_resp_t         resp_i,
	output logic                                l2_req_valid_o,
	output l1_store_pkg::l2_req_t               l2_req_o,
	output logic [l1_store_pkg::LINE_BITS-1:0]  bypass_data_o,
	output logic [l1_store_pkg::MASK_BITS-1:0]  bypass_mask_o,
	output logic                                rollback_o,
	output l1_store_pkg::strand_mask_t          resume_strands_o,
	output logic                                store_update_o,
	output logic [l1_store_pkg::SET_W-1:0]      store_update_set_o
);

	l1_store_pkg::strand_mask_t pending;
	l1_store_pkg::strand_mask_t grant;
	l1_store_pkg::strand_mask_t entry_busy;
	l1_store_pkg::strand_mask_t sync_resume;
	l1_store_pkg::strand_mask_t sync_result;
	logic                       rotate;
	logic                       need_sync_rollback;
	logic                       sync_rollback;

	store_buffer u_store_buffer
	(
		.clk                  (clk),
		.rst_n_i              (rst_n_i),
		.req_i                (req_i),
		.need_sync_rollback_i (need_sync_rollback),
		.sync_result_i        (sync_result),
		.sync_resume_i        (sync_resume),
		.sync_rollback_i      (sync_rollback),
		.grant_i              (grant),
		.resp_i               (resp_i),
		.l2_ack_i             (l2_ack_i),
		.pending_o            (pending),
		.rotate_o             (rotate),
		.entry_busy_o         (entry_busy),
		.l2_req_valid_o       (l2_req_valid_o),
		.l2_req_o             (l2_req_o),
		.bypass_data_o        (bypass_data_o),
		.bypass_mask_o        (bypass_mask_o),
		.rollback_o           (rollback_o),
		.resume_strands_o     (resume_strands_o),
		.store_update_o       (store_update_o),
		.store_update_set_o   (store_update_set_o)
	);

	rr_arbiter4 u_arbiter
	(
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.request_i (pending),
		.rotate_i  (rotate),
		.grant_o   (grant)
	);

	sync_store_tracker u_sync_tracker
	(
		.clk                  (clk),
		.rst_n_i              (rst_n_i),
		.req_i                (req_i),
		.entry_busy_i         (entry_busy),
		.resp_i               (resp_i),
		.need_sync_rollback_o (need_sync_rollback),
		.sync_rollback_o      (sync_rollback),
		.sync_resume_o        (sync_resume),
		.sync_result_o        (sync_result)
	);

endmodule

`default_nettype wire

// ==== verif/store_subsystem_tb.sv ====
// Testbench for the L1 store path; runs a table of stores and probes against an L2 model
`default_nettype none
`timescale 1ns/100ps

module store_subsystem_tb;

	localparam int BYP_SKIP = 0;
	localparam int BYP_ZERO = 1;
	localparam int BYP_HIT = 2;
	localparam int BYP_SYNC = 3;

	typedef struct
	{
		l1_store_pkg::store_req_t   req;
		logic                       status;
		logic                       update;
		logic                       exp_rollback;
		logic                       exp_req;
		int                         byp_kind;
		int                         wait_strand;
		l1_store_pkg::strand_mask_t exp_resume;
		int                         budget;
	} row_t;

	logic                                clk;
	logic                                rst_n;
	l1_store_pkg::store_req_t            req_r;
	logic                                ack_r;
	l1_store_pkg::l2_resp_t              resp_r;
	logic                                l2_req_valid;
	l1_store_pkg::l2_req_t               l2_req;
	logic [l1_store_pkg::LINE_BITS-1:0]  bypass_data;
	logic [l1_store_pkg::MASK_BITS-1:0]  bypass_mask;
	logic                                rollback;
	l1_store_pkg::strand_mask_t          resume_strands;
	logic                                store_update;
	logic [l1_store_pkg::SET_W-1:0]      store_update_set;

	row_t rows [$];
	// Expected L2 requests in issue order with the model's ack and response timing
	l1_store_pkg::l2_req_t exp_req_tab [16];
	int   exp_ack_tab [16];
	int   exp_resp_tab [16];
	logic exp_status_tab [16];
	logic exp_update_tab [16];
	// Last store enqueued per strand
	logic [l1_store_pkg::SET_W-1:0]     ent_set [4];
	logic                               ent_update [4];
	logic [l1_store_pkg::MASK_BITS-1:0] ent_mask [4];
	logic [l1_store_pkg::LINE_BITS-1:0] ent_data [4];
	int num_exp = 0;
	int seen_count = 0;
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	integer seed;

	store_subsystem u_dut
	(
		.clk                (clk),
		.rst_n_i            (rst_n),
		.req_i              (req_r),
		.l2_ack_i           (ack_r),
		.resp_i             (resp_r),
		.l2_req_valid_o     (l2_req_valid),
		.l2_req_o           (l2_req),
		.bypass_data_o      (bypass_data),
		.bypass_mask_o      (bypass_mask),
		.rollback_o         (rollback),
		.resume_strands_o   (resume_strands),
		.store_update_o     (store_update),
		.store_update_set_o (store_update_set)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic compare_l2_req(input string name, input l1_store_pkg::l2_req_t got,
		input l1_store_pkg::l2_req_t exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic verify_strand_mask(input string name, input l1_store_pkg::strand_mask_t got,
		input l1_store_pkg::strand_mask_t exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_line(input string name,
		input logic [l1_store_pkg::LINE_BITS-1:0] got_data,
		input logic [l1_store_pkg::MASK_BITS-1:0] got_mask,
		input logic [l1_store_pkg::LINE_BITS-1:0] exp_data,
		input logic [l1_store_pkg::MASK_BITS-1:0] exp_mask);
		if (got_mask !== exp_mask || got_data !== exp_data)
		begin
			$display("FAILED at %0t: %s mask %h data %h, expected mask %h data %h",
				$time, name, got_mask, got_data, exp_mask, exp_data);
			errors++;
		end
	endtask

	task automatic compare_set(input string name, input logic [l1_store_pkg::SET_W-1:0] got,
		input logic [l1_store_pkg::SET_W-1:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Mask and data of a store are byte patterns built from one fill value
	task automatic add_row(input logic w, input logic sy, input int st, input logic [19:0] tag,
		input logic [5:0] set, input logic [7:0] fill, input logic status, input logic update,
		input int ack, input int resp, input logic rb, input logic rq, input int seq,
		input int byp, input int ws, input l1_store_pkg::strand_mask_t resume, input int budget);
		row_t r;
		r.req.write = w;
		r.req.synchronized = sy;
		r.req.strand = st[1:0];
		r.req.tag = tag;
		r.req.set = set;
		r.req.mask = {8{fill}};
		r.req.data = {64{fill}};
		r.status = status;
		r.update = update;
		r.exp_rollback = rb;
		r.exp_req = rq;
		r.byp_kind = byp;
		r.wait_strand = ws;
		r.exp_resume = resume;
		r.budget = budget;
		rows.push_back(r);
		if (rq)
		begin
			exp_req_tab[seq].op = sy ? l1_store_pkg::L2_STORE_SYNC : l1_store_pkg::L2_STORE;
			exp_req_tab[seq].strand = st[1:0];
			exp_req_tab[seq].address = {tag, set};
			exp_req_tab[seq].mask = {8{fill}};
			exp_req_tab[seq].data = {64{fill}};
			exp_ack_tab[seq] = ack;
			exp_resp_tab[seq] = resp;
			exp_status_tab[seq] = status;
			exp_update_tab[seq] = update;
			num_exp++;
		end
	endtask

	task automatic build_table();
		// w sy st tag set fill | status update ack resp | rb req seq bypass wait resume budget
		// An ack delay of -1 draws a random delay of 0 to 3 cycles
		add_row(1, 0, 0, 20'h12345, 6'd5, 8'ha5, 0, 1, 2, 14, 0, 1, 0, BYP_SKIP, -1, 4'h0, 4);
		add_row(0, 0, 0, 20'h12345, 6'd5, 8'h00, 0, 0, 0, 0, 0, 0, 0, BYP_HIT, -1, 4'h0, 4);
		add_row(0, 0, 1, 20'h12345, 6'd5, 8'h00, 0, 0, 0, 0, 0, 0, 0, BYP_ZERO, -1, 4'h0, 4);
		add_row(0, 0, 0, 20'h12345, 6'd6, 8'h00, 0, 0, 0, 0, 0, 0, 0, BYP_ZERO, 0, 4'h0, 30);
		add_row(1, 0, 1, 20'habcde, 6'd9, 8'h3c, 0, 0, 4, 6, 0, 1, 1, BYP_SKIP, -1, 4'h0, 4);
		add_row(1, 0, 1, 20'h00111, 6'd10, 8'h77, 0, 0, 0, 0, 1, 0, 0, BYP_SKIP, 1, 4'h2, 30);
		add_row(1, 0, 3, 20'h0f0f0, 6'd63, 8'h5a, 1, 1, -1, 2, 0, 1, 2, BYP_SKIP, 3, 4'h0, 20);
		add_row(1, 1, 2, 20'h2468a, 6'd17, 8'hc3, 1, 0, -1, 3, 1, 1, 3, BYP_SKIP, 2, 4'h4, 20);
		add_row(1, 1, 2, 20'h2468a, 6'd17, 8'hc3, 1, 0, 0, 0, 0, 0, 0, BYP_SYNC, -1, 4'h0, 4);
		// Strand 3 is granted alone, then the others follow in rotating order 0, 1, 2
		add_row(1, 0, 3, 20'h11111, 6'd1, 8'h01, 0, 1, 6, 2, 0, 1, 4, BYP_SKIP, -1, 4'h0, 4);
		add_row(1, 0, 2, 20'h22222, 6'd2, 8'h02, 1, 0, 3, 2, 0, 1, 7, BYP_SKIP, -1, 4'h0, 4);
		add_row(1, 0, 1, 20'h33333, 6'd3, 8'h03, 0, 1, 3, 2, 0, 1, 6, BYP_SKIP, -1, 4'h0, 4);
		add_row(1, 0, 0, 20'h44444, 6'd4, 8'h04, 1, 1, 3, 2, 0, 1, 5, BYP_SKIP, -1, 4'h0, 4);
		add_row(0, 0, 0, 20'h00000, 6'd0, 8'h00, 0, 0, 0, 0, 0, 0, 0, BYP_SKIP, 2, 4'h0, 50);
	endtask

	// Response cycle carries the update strobe; the resume pulse follows one cycle later
	task automatic wait_response(input int s, input l1_store_pkg::strand_mask_t resume,
		input int budget);
		int waited;
		waited = 0;
		while (!(resp_r.valid && resp_r.strand == s[1:0]) && waited < budget)
		begin
			@(negedge clk);
			waited++;
		end
		if (waited >= budget)
		begin
			$display("No L2 response for strand %0d within %0d cycles", s, budget);
			errors++;
		end
		else
		begin
			expect_level("store_update_o", store_update, ent_update[s]);
			compare_set("store_update_set_o", store_update_set, ent_set[s]);
			@(negedge clk);
			verify_strand_mask("resume_strands_o", resume_strands, resume);
		end
	endtask

	task automatic run_row(input int i);
		row_t r;
		logic [l1_store_pkg::LINE_BITS-1:0] exp_data;
		int s;
		r = rows[i];
		s = r.req.strand;
		@(posedge clk);
		req_r <= r.req;
		if (r.exp_req)
		begin
			ent_set[s] = r.req.set;
			ent_update[s] = r.update;
			ent_mask[s] = r.req.mask;
			ent_data[s] = r.req.data;
		end
		@(posedge clk);
		req_r <= '0;
		@(negedge clk);
		expect_level("rollback_o", rollback, r.exp_rollback);
		if (r.byp_kind == BYP_ZERO)
			compare_line("bypass", bypass_data, bypass_mask, '0, '0);
		else if (r.byp_kind == BYP_HIT)
			compare_line("bypass", bypass_data, bypass_mask, ent_data[s], ent_mask[s]);
		else if (r.byp_kind == BYP_SYNC)
		begin
			exp_data = '0;
			for (int w = 0; w < l1_store_pkg::LINE_BITS / 32; w++)
				exp_data[w*32] = r.status;
			compare_line("bypass", bypass_data, bypass_mask, exp_data, '1);
		end
		if (r.wait_strand >= 0)
			wait_response(r.wait_strand, r.exp_resume, r.budget);
	endtask

	// The L2 model checks each request on arrival and while held, acks it, then answers later
	initial
	begin
		l1_store_pkg::l2_req_t  held;
		l1_store_pkg::l2_resp_t rsp_next;
		logic                   ack_next;
		logic                   in_flight;
		int                     count;
		int                     dly;
		int                     cyc;
		int                     cur_seq;
		int                     s;
		int                     due_q [$];
		int                     seq_q [$];
		ack_r = 1'b0;
		resp_r = '0;
		seed = 32'h37f6_d76c;
		in_flight = 1'b0;
		count = 0;
		dly = 0;
		cyc = 0;
		cur_seq = 0;
		forever
		begin
			@(negedge clk);
			cyc++;
			ack_next = 1'b0;
			rsp_next = '0;
			if (l2_req_valid)
			begin
				if (!in_flight)
				begin
					cur_seq = seen_count % 16;
					if (seen_count < num_exp)
						compare_l2_req("l2_req_o", l2_req, exp_req_tab[cur_seq]);
					else
					begin
						$display("L2 model got an extra request from strand %0d", l2_req.strand);
						errors++;
					end
					held = l2_req;
					in_flight = 1'b1;
					count = 0;
					if (exp_ack_tab[cur_seq] < 0)
						dly = $unsigned($random(seed)) % 4;
					else
						dly = exp_ack_tab[cur_seq];
					seen_count++;
				end
				else
					compare_l2_req("l2_req_o while held", l2_req, held);
				if (ack_r)
				begin
					in_flight = 1'b0;
					due_q.push_back(cyc + exp_resp_tab[cur_seq]);
					seq_q.push_back(cur_seq);
				end
				else if (count >= dly)
					ack_next = 1'b1;
				else
					count++;
			end
			if (due_q.size() > 0 && due_q[0] <= cyc + 1)
			begin
				s = seq_q.pop_front();
				void'(due_q.pop_front());
				rsp_next = {1'b1, exp_status_tab[s], 1'b1, exp_req_tab[s].strand, exp_update_tab[s]};
			end
			@(posedge clk);
			ack_r <= ack_next;
			resp_r <= rsp_next;
		end
	end

	initial
	begin
		while (cycle_count <= cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles without finishing", cycle_count);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		int total;
		int row_errs;
		int passed;
		int failed;
		total = 0;
		passed = 0;
		failed = 0;
		req_r = '0;
		rst_n = 1'b0;
		build_table();
		foreach (rows[i])
			total += rows[i].budget;
		cycle_limit = total + 50;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		foreach (rows[i])
		begin
			row_errs = errors;
			run_row(i);
			if (errors == row_errs)
				passed++;
			else
				failed++;
			$display("Row %0d strand %0d write %0b sync %0b: %s", i, rows[i].req.strand,
				rows[i].req.write, rows[i].req.synchronized, (errors == row_errs) ? "pass" : "fail");
		end
		@(negedge clk);
		expect_level("l2_req_valid_o", l2_req_valid, 1'b0);
		if (seen_count != num_exp)
		begin
			$display("L2 model saw %0d requests where %0d were expected", seen_count, num_exp);
			errors++;
		end
		$display("Rows passed %0d, rows failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0 && failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== store_subsystem.f ====
verilog/l1_store_pkg.sv
verilog/rr_arbiter4.sv
verilog/sync_store_tracker.sv
verilog/store_buffer.sv
verilog/store_subsystem.sv
verif/store_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f store_subsystem.f --top-module store_subsystem_tb
out=$(./obj_dir/Vstore_subsystem_tb)
echo "$out"
if echo "$out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1
